//--- hw/uart_rx_pkg.sv
/*
 * Shared types, sizes and the character-time function of the UART
 * receive path. Imported by the framer, line timer, FIFO and top level.
 * The testbench uses the record layout and char_ticks from here too.
 */
package uart_rx_pkg;

    // Receive FIFO geometry
    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_COUNT_W = 5;

    // Serial line oversampling, ticks per bit and mid-bit sample tick
    localparam int OVERSAMPLE   = 16;
    localparam int SAMPLE_POINT = 7;
    localparam int TICK_W       = $clog2(OVERSAMPLE);

    // Line timer counters
    localparam int TIMEOUT_W = 10;
    localparam int BREAK_W   = 8;

    // Receiver FSM states
    typedef enum logic [3:0] {
        rx_idle,
        rx_start,
        rx_prepare,
        rx_bit,
        rx_end_bit,
        rx_parity,
        rx_parity_calc,
        rx_parity_check,
        rx_wait,
        rx_stop,
        rx_push
    } rx_state_e;

    // Line format, laid out as bits 5..0 of the line-control byte
    typedef struct packed {
        logic       stick_parity;
        logic       even_parity;
        logic       parity_en;
        logic       two_stop;
        logic [1:0] word_len;
    } line_fmt_t;

    // One FIFO entry
    typedef struct packed {
        logic [7:0] data;
        logic       break_flag;
        logic       parity_err;
        logic       framing_err;
    } rx_record_t;

    // Four character times in ticks, minus one
    // Counted in half bits so that 1.5 stop bits come out exact
    function automatic logic [TIMEOUT_W-1:0] char_ticks(line_fmt_t fmt);
        int half_bits;
        // Start, 5..8 data bits, optional parity, one stop
        half_bits = 2 * (7 + int'(fmt.word_len) + int'(fmt.parity_en));
        if (fmt.two_stop) begin
            half_bits += (fmt.word_len == 2'd0) ? 1 : 2;
        end
        return TIMEOUT_W'(half_bits * 32 - 1);
    endfunction

endpackage

//--- hw/uart_rx_framer.sv
/*
 * Oversampling receive FSM of the UART.
 * Confirms the start bit at mid-bit, shifts in the data bits, checks
 * parity and the stop bit, and hands one record per character to the FIFO
 * with a single-cycle push pulse. Advances only on baud_tick.
 */
`timescale 1ns/1ns

module uart_rx_framer (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    baud_tick,
    input  logic                    serial_in,
    input  uart_rx_pkg::line_fmt_t  fmt,
    input  logic                    break_seen,
    output logic                    push,
    output uart_rx_pkg::rx_record_t push_record
);
    import uart_rx_pkg::*;

    rx_state_e         state;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    logic [7:0]        shift_reg;
    logic              parity_bit;
    logic              parity_xor;
    logic              parity_err;
    logic              framing_err;
    logic              push_reg;
    logic              push_q;

    logic              at_sample;
    logic              at_zero;
    logic [TICK_W-1:0] tick_dec;
    logic [TICK_W-1:0] tick_reload;
    rx_record_t        char_record;
    rx_record_t        break_record;

    // Tick counter decodes
    assign at_sample = (tick_cnt == TICK_W'(SAMPLE_POINT));
    assign at_zero   = (tick_cnt == '0);
    assign tick_dec  = tick_cnt - 1'b1;
    // One tick of every bit is spent in the state that ends the bit
    assign tick_reload = TICK_W'(OVERSAMPLE - 2);

    // Record of a normal character
    assign char_record = '{data: shift_reg, break_flag: 1'b0,
                           parity_err: parity_err, framing_err: framing_err};
    // Break is stored as an empty character
    assign break_record = '{data: 8'h00, break_flag: 1'b1,
                            parity_err: 1'b0, framing_err: 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Receiver FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state       <= rx_idle;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            shift_reg   <= '0;
            parity_bit  <= 1'b0;
            parity_xor  <= 1'b0;
            parity_err  <= 1'b0;
            framing_err <= 1'b0;
            push_reg    <= 1'b0;
            push_record <= '0;
        end else if (baud_tick) begin
            case (state)
                rx_idle: begin
                    push_reg <= 1'b0;
                    tick_cnt <= tick_reload;
                    // Falling edge, but not while the line sits in break
                    if (!serial_in && !break_seen) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    push_reg <= 1'b0;
                    // Line back high at mid-bit means a glitch
                    if (at_sample) begin
                        state <= serial_in ? rx_idle : rx_prepare;
                    end
                    tick_cnt <= tick_dec;
                end
                rx_prepare: begin
                    // Data bits minus one, 4..7
                    bit_cnt <= {1'b1, fmt.word_len};
                    if (at_zero) begin
                        state     <= rx_bit;
                        shift_reg <= '0;
                    end
                    tick_cnt <= tick_dec;
                end
                rx_bit: begin
                    if (at_zero) begin
                        state <= rx_end_bit;
                    end
                    // LSB first, shifted into the low word_len+5 bits only
                    if (at_sample) begin
                        case (fmt.word_len)
                            2'd0: shift_reg[4:0] <= {serial_in, shift_reg[4:1]};
                            2'd1: shift_reg[5:0] <= {serial_in, shift_reg[5:1]};
                            2'd2: shift_reg[6:0] <= {serial_in, shift_reg[6:1]};
                            default: shift_reg <= {serial_in, shift_reg[7:1]};
                        endcase
                    end
                    tick_cnt <= tick_dec;
                end
                rx_end_bit: begin
                    if (bit_cnt == '0) begin
                        if (fmt.parity_en) begin
                            state <= rx_parity;
                        end else begin
                            state      <= rx_stop;
                            parity_err <= 1'b0;
                        end
                    end else begin
                        state   <= rx_bit;
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                    tick_cnt <= tick_reload;
                end
                rx_parity: begin
                    if (at_sample) begin
                        parity_bit <= serial_in;
                        state      <= rx_parity_calc;
                    end
                    tick_cnt <= tick_dec;
                end
                rx_parity_calc: begin
                    // XOR over data and received parity bit
                    parity_xor <= ^{shift_reg, parity_bit};
                    state      <= rx_parity_check;
                    tick_cnt   <= tick_dec;
                end
                rx_parity_check: begin
                    case ({fmt.even_parity, fmt.stick_parity})
                        2'b00: parity_err <= ~parity_xor;   // odd
                        2'b01: parity_err <= ~parity_bit;   // stuck to 1
                        2'b10: parity_err <= parity_xor;    // even
                        2'b11: parity_err <= parity_bit;    // stuck to 0
                        default: parity_err <= 1'b0;
                    endcase
                    state    <= rx_wait;
                    tick_cnt <= tick_dec;
                end
                rx_wait: begin
                    // Rest of the parity bit
                    if (at_zero) begin
                        state    <= rx_stop;
                        tick_cnt <= tick_reload;
                    end else begin
                        tick_cnt <= tick_dec;
                    end
                end
                rx_stop: begin
                    if (at_sample) begin
                        framing_err <= !serial_in;
                        state       <= rx_push;
                    end
                    tick_cnt <= tick_dec;
                end
                rx_push: begin
                    if (serial_in || break_seen) begin
                        push_record <= break_seen ? break_record : char_record;
                        push_reg    <= 1'b1;
                        state       <= rx_idle;
                    end else if (!framing_err) begin
                        // Good stop bit with the line low, take it as a new start
                        push_record <= char_record;
                        push_reg    <= 1'b1;
                        tick_cnt    <= tick_reload;
                        state       <= rx_start;
                    end
                    // Framing error on a low line waits for rise or break
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // push_reg may span several cycles between ticks
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            push_q <= 1'b0;
        end else begin
            push_q <= push_reg;
        end
    end

    assign push = push_reg & ~push_q;

endmodule

//--- hw/uart_rx_line_timer.sv
/*
 * Break and character-timeout counters of the UART receiver.
 * Both reload from the character time of the current line format and
 * count down on baud ticks. The framer reads break_seen.
 */
`timescale 1ns/1ns

module uart_rx_line_timer (
    input  logic                   clk,
    input  logic                   nreset,
    input  logic                   baud_tick,
    input  logic                   serial_in,
    input  uart_rx_pkg::line_fmt_t fmt,
    input  logic                   push,
    input  logic                   rx_pop,
    input  logic                   empty,
    output logic                   break_seen,
    output logic                   char_timeout
);
    import uart_rx_pkg::*;

    logic [TIMEOUT_W-1:0] toc_value;
    logic [TIMEOUT_W-1:0] toc_cnt;
    logic [BREAK_W-1:0]   brc_value;
    logic [BREAK_W-1:0]   brc_cnt;

    // Four character times for timeout
    assign toc_value = char_ticks(fmt);
    // One character time for break, toc_value / 4
    assign brc_value = toc_value[TIMEOUT_W-1 -: BREAK_W];

    ////////////////////////////////////////////////////////////////////////////
    // Break detection
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            // One 8N1 character
            brc_cnt <= BREAK_W'(159);
        end else if (serial_in) begin
            brc_cnt <= brc_value;
        end else if (baud_tick && brc_cnt != '0) begin
            brc_cnt <= brc_cnt - 1'b1;
        end
    end

    assign break_seen = (brc_cnt == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Character timeout
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            // Four 8N1 characters
            toc_cnt <= TIMEOUT_W'(639);
        end else if (push || rx_pop || empty) begin
            // Any FIFO activity, or nothing to time out on
            toc_cnt <= toc_value;
        end else if (baud_tick && toc_cnt != '0) begin
            toc_cnt <= toc_cnt - 1'b1;
        end
    end

    // Empty mask covers the cycle right after a FIFO clear
    assign char_timeout = (toc_cnt == '0) & ~empty;

endmodule

//--- hw/uart_rx_fifo.sv
/*
 * Sixteen-entry first-word-fall-through FIFO for received records.
 * Head record is visible while count is nonzero and pop removes it.
 * Tracks a sticky overrun flag and whether any stored entry has an error.
 */
`timescale 1ns/1ns

module uart_rx_fifo (
    input  logic                                 clk,
    input  logic                                 nreset,
    input  logic                                 push,
    input  uart_rx_pkg::rx_record_t              push_record,
    input  logic                                 pop,
    input  logic                                 clear,
    output uart_rx_pkg::rx_record_t              head,
    output logic [uart_rx_pkg::FIFO_COUNT_W-1:0] count,
    output logic                                 empty,
    output logic                                 overrun,
    output logic                                 error_in_fifo
);
    import uart_rx_pkg::*;

    rx_record_t              mem [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0]   err_valid;
    logic [FIFO_COUNT_W-2:0] wr_ptr;
    logic [FIFO_COUNT_W-2:0] rd_ptr;
    logic                    full;
    logic                    do_push;
    logic                    do_pop;

    assign empty = (count == '0);
    assign full  = (count == FIFO_COUNT_W'(FIFO_DEPTH));
    assign do_pop = pop & ~empty;
    // Full FIFO still takes a push when the head leaves in the same cycle
    assign do_push = push & (~full | pop);

    // Record storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_record;
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overrun   <= 1'b0;
            err_valid <= '0;
        end else if (clear) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overrun   <= 1'b0;
            err_valid <= '0;
        end else begin
            // Popped slot first, so a push into the same slot wins
            if (do_pop) begin
                rd_ptr            <= rd_ptr + 1'b1;
                err_valid[rd_ptr] <= 1'b0;
            end
            if (do_push) begin
                wr_ptr            <= wr_ptr + 1'b1;
                err_valid[wr_ptr] <= push_record.break_flag |
                                     push_record.parity_err |
                                     push_record.framing_err;
            end
            if (push && !do_push) begin
                overrun <= 1'b1;
            end
            count <= count + FIFO_COUNT_W'(do_push) - FIFO_COUNT_W'(do_pop);
        end
    end

    assign head          = mem[rd_ptr];
    assign error_in_fifo = |err_valid;

endmodule

//--- hw/uart_rx_top.sv
/*
 * Top level of the UART receive path.
 * Takes the line-control byte, the 16x baud tick and the serial line,
 * and presents the head of the receive FIFO with its status flags.
 */
`timescale 1ns/1ns

module uart_rx_top (
    input  logic                                 clk,
    input  logic                                 nreset,
    input  logic [7:0]                           lcr,
    input  logic                                 baud_tick,
    input  logic                                 serial_in,
    input  logic                                 rx_pop,
    input  logic                                 fifo_clear,
    output logic [10:0]                          rx_data,
    output logic [uart_rx_pkg::FIFO_COUNT_W-1:0] rx_count,
    output logic                                 overrun,
    output logic                                 error_in_fifo,
    output logic                                 char_timeout,
    output logic                                 rx_push
);
    import uart_rx_pkg::*;

    line_fmt_t  fmt;
    rx_record_t push_record;
    rx_record_t head;
    logic       push;
    logic       break_seen;
    logic       empty;

    // Word length, stop bits and parity mode live in lcr[5:0]
    assign fmt = line_fmt_t'(lcr[5:0]);

    uart_rx_framer u_framer (
        .clk         (clk),
        .nreset      (nreset),
        .baud_tick   (baud_tick),
        .serial_in   (serial_in),
        .fmt         (fmt),
        .break_seen  (break_seen),
        .push        (push),
        .push_record (push_record)
    );

    uart_rx_line_timer u_line_timer (
        .clk          (clk),
        .nreset       (nreset),
        .baud_tick    (baud_tick),
        .serial_in    (serial_in),
        .fmt          (fmt),
        .push         (push),
        .rx_pop       (rx_pop),
        .empty        (empty),
        .break_seen   (break_seen),
        .char_timeout (char_timeout)
    );

    uart_rx_fifo u_fifo (
        .clk           (clk),
        .nreset        (nreset),
        .push          (push),
        .push_record   (push_record),
        .pop           (rx_pop),
        .clear         (fifo_clear),
        .head          (head),
        .count         (rx_count),
        .empty         (empty),
        .overrun       (overrun),
        .error_in_fifo (error_in_fifo)
    );

    assign rx_data = head;
    assign rx_push = push;

endmodule

//--- dv/uart_rx_properties.sv
/*
 * Concurrent checks on the top-level ports of the UART receive path.
 * Bound to every uart_rx_top instance.
 */
`timescale 1ns/1ns

module uart_rx_properties (
    input logic                                 clk,
    input logic                                 nreset,
    input logic                                 rx_push,
    input logic [uart_rx_pkg::FIFO_COUNT_W-1:0] rx_count,
    input logic                                 char_timeout,
    input logic                                 fifo_clear
);
    import uart_rx_pkg::*;

    // Push is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!nreset) rx_push |=> !rx_push)
        else $error("rx_push held for more than one cycle");

    assert property (@(posedge clk) disable iff (!nreset)
                     rx_count <= FIFO_COUNT_W'(FIFO_DEPTH))
        else $error("rx_count above FIFO depth");

    // Timeout only with data waiting
    assert property (@(posedge clk) disable iff (!nreset) char_timeout |-> rx_count != '0)
        else $error("char_timeout with an empty FIFO");

    assert property (@(posedge clk) disable iff (!nreset) fifo_clear |=> rx_count == '0)
        else $error("FIFO not empty after clear");

endmodule

bind uart_rx_top uart_rx_properties u_properties (
    .clk          (clk),
    .nreset       (nreset),
    .rx_push      (rx_push),
    .rx_count     (rx_count),
    .char_timeout (char_timeout),
    .fifo_clear   (fifo_clear)
);

//--- dv/uart_rx_tb.sv
/*
 * Testbench for the UART receive path.
 * Drives serial frames from an LFSR, predicts each FIFO record with a
 * reference function and pops and compares in a separate checking process.
 * Covers clean 8N1, mixed formats with parity faults, framing errors,
 * break, overrun and character timeout.
 */
`timescale 1ns/1ns

module uart_rx_tb;
    import uart_rx_pkg::*;

    localparam logic [31:0] SEED = 32'h8565_a24e;
    localparam int N_CLEAN = 24;
    localparam int N_FMT = 24;
    localparam int N_OVR = FIFO_DEPTH + 2;
    localparam int MAX_FRAME_TICKS = 12 * OVERSAMPLE;
    // Clean frames run at full rate and again at a third of it
    // Twelve extra frame slots cover the clear, the break and the timeout
    localparam int CYCLE_LIMIT = 2 * MAX_FRAME_TICKS * (N_CLEAN * 4 + N_FMT + N_OVR + 12);

    logic                    clk;
    logic                    nreset;
    logic [7:0]              lcr;
    logic                    baud_tick;
    logic                    serial_in;
    logic                    rx_pop;
    logic                    fifo_clear;
    logic [10:0]             rx_data;
    logic [FIFO_COUNT_W-1:0] rx_count;
    logic                    overrun;
    logic                    error_in_fifo;
    logic                    char_timeout;
    logic                    rx_push;

    logic [31:0]  lfsr_state;
    int           tick_div;
    int           tick_phase;
    int           tick_total;
    int           cycle_count;
    logic         auto_pop;
    logic         expect_clean;
    rx_record_t   expected_q[$];
    rx_record_t   exp_rec;

    uart_rx_top UUT (
        .clk           (clk),
        .nreset        (nreset),
        .lcr           (lcr),
        .baud_tick     (baud_tick),
        .serial_in     (serial_in),
        .rx_pop        (rx_pop),
        .fifo_clear    (fifo_clear),
        .rx_data       (rx_data),
        .rx_count      (rx_count),
        .overrun       (overrun),
        .error_in_fifo (error_in_fifo),
        .char_timeout  (char_timeout),
        .rx_push       (rx_push)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR step, taken once per bit
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function logic [31:0] take_bits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Low word_len+5 bits valid
    function automatic logic [7:0] data_mask(line_fmt_t fmt);
        return 8'hff >> (2'd3 - fmt.word_len);
    endfunction

    // Expected FIFO record for one character
    function automatic rx_record_t expected_record(logic [7:0] data, line_fmt_t fmt,
                                                   logic flip, logic bad_stop);
        rx_record_t rec;
        rec.data        = data & data_mask(fmt);
        rec.break_flag  = 1'b0;
        rec.parity_err  = fmt.parity_en & flip;
        rec.framing_err = bad_stop;
        return rec;
    endfunction

    // Whole frame length in ticks with half a stop bit extra for 5-bit words
    function automatic int frame_ticks(line_fmt_t fmt);
        int t;
        t = OVERSAMPLE * (7 + int'(fmt.word_len) + int'(fmt.parity_en));
        if (fmt.two_stop) begin
            t += (fmt.word_len == 2'd0) ? OVERSAMPLE / 2 : OVERSAMPLE;
        end
        return t;
    endfunction

    task automatic fail_check(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    // Hold the current line value for n DUT-visible ticks
    task automatic hold_ticks(int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (baud_tick) begin
                seen++;
            end
        end
    endtask

    task automatic send_bit(logic b, int n);
        serial_in <= b;
        hold_ticks(n);
    endtask

    task automatic send_frame(logic [7:0] data, line_fmt_t fmt, logic flip, logic bad_stop);
        logic par;
        par = ^(data & data_mask(fmt));
        if (!fmt.even_parity) begin
            par = ~par;
        end
        if (fmt.stick_parity) begin
            par = ~fmt.even_parity;
        end
        send_bit(1'b0, OVERSAMPLE);
        for (int i = 0; i < int'(fmt.word_len) + 5; i++) begin
            send_bit(data[i], OVERSAMPLE);
        end
        if (fmt.parity_en) begin
            send_bit(par ^ flip, OVERSAMPLE);
        end
        send_bit(~bad_stop, OVERSAMPLE);
        if (fmt.two_stop) begin
            send_bit(1'b1, (fmt.word_len == 2'd0) ? OVERSAMPLE / 2 : OVERSAMPLE);
        end
        // Let a bad stop bit be followed by a high line
        if (bad_stop) begin
            send_bit(1'b1, OVERSAMPLE);
        end
    endtask

    task automatic wait_cond_count(int n, string what);
        int c;
        c = 0;
        while (rx_count != FIFO_COUNT_W'(n)) begin
            @(posedge clk);
            c++;
            if (c > 4 * MAX_FRAME_TICKS) begin
                fail_check($sformatf("rx_count never reached %0d while %s", n, what));
            end
        end
    endtask

    // Wait until the checker has emptied FIFO and queue
    task automatic wait_drain(string what);
        int c;
        c = 0;
        while (expected_q.size() != 0 || rx_count != '0 || rx_pop) begin
            @(posedge clk);
            c++;
            if (c > 4 * MAX_FRAME_TICKS) begin
                fail_check($sformatf("Expected records never arrived during %s", what));
            end
        end
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Clock, tick, watchdog and checker
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        tick_phase <= (tick_phase + 1 >= tick_div) ? 0 : tick_phase + 1;
        baud_tick  <= (tick_phase == 0);
        if (baud_tick) begin
            tick_total <= tick_total + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "Watchdog expired");
        end
    end

    // Pop one record every other cycle and compare it with the queue head
    always @(posedge clk) begin
        if (!nreset || rx_pop) begin
            rx_pop <= 1'b0;
        end else if (auto_pop && rx_count != '0) begin
            assert (expected_q.size() != 0)
                else fail_check("A record arrived in the FIFO when none was expected");
            exp_rec = expected_q.pop_front();
            assert (rx_data == exp_rec)
                else fail_check($sformatf("Mismatch at %0t: rx_data expected %h got %h",
                                          $time, exp_rec, rx_data));
            rx_pop <= 1'b1;
        end
        if (nreset && expect_clean) begin
            assert (!error_in_fifo)
                else fail_check($sformatf("Mismatch at %0t: error_in_fifo expected 0 got 1",
                                          $time));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        line_fmt_t  fmt;
        logic [7:0] data;
        logic       flip;
        int         start_ticks;
        int         elapsed;
        int         c;

        nreset       = 1'b0;
        lcr          = 8'h03;
        baud_tick    = 1'b0;
        serial_in    = 1'b1;
        fifo_clear   = 1'b0;
        rx_pop       = 1'b0;
        lfsr_state   = SEED;
        tick_div     = 1;
        tick_phase   = 0;
        tick_total   = 0;
        cycle_count  = 0;
        auto_pop     = 1'b1;
        expect_clean = 1'b0;
        repeat (16) @(posedge clk);
        nreset <= 1'b1;
        repeat (4) @(posedge clk);

        // Clean 8N1 back to back at full rate and at one tick in three
        fmt = line_fmt_t'(6'h03);
        expect_clean <= 1'b1;
        for (int pass = 0; pass < 2; pass++) begin
            tick_div = (pass == 0) ? 1 : 3;
            for (int i = 0; i < N_CLEAN; i++) begin
                data = 8'(take_bits(8));
                expected_q.push_back(expected_record(data, fmt, 1'b0, 1'b0));
                send_frame(data, fmt, 1'b0, 1'b0);
            end
            wait_drain("clean 8N1 frames");
        end
        expect_clean <= 1'b0;
        tick_div = 1;

        // Short words, stop bits and every parity mode with some bad parity bits
        for (int i = 0; i < N_FMT; i++) begin
            fmt.word_len     = 2'(take_bits(2) % 3);
            fmt.two_stop     = 1'(take_bits(1));
            fmt.parity_en    = 1'b1;
            fmt.even_parity  = 1'(take_bits(1));
            fmt.stick_parity = 1'(take_bits(1));
            flip = 1'(take_bits(1));
            data = 8'(take_bits(8));
            @(posedge clk);
            lcr <= {2'b00, fmt};
            @(posedge clk);
            expected_q.push_back(expected_record(data, fmt, flip, 1'b0));
            send_frame(data, fmt, flip, 1'b0);
        end
        wait_drain("format and parity frames");

        // Framing error with the last data bit high so the low run stays short of a break
        fmt = line_fmt_t'(6'h03);
        @(posedge clk);
        lcr <= 8'h03;
        auto_pop <= 1'b0;
        data = 8'(take_bits(8)) | 8'h80;
        expected_q.push_back(expected_record(data, fmt, 1'b0, 1'b1));
        send_frame(data, fmt, 1'b0, 1'b1);
        wait_cond_count(1, "waiting for the framing error record");
        @(posedge clk);
        assert (error_in_fifo)
            else fail_check($sformatf("Mismatch at %0t: error_in_fifo expected 1 got 0", $time));
        auto_pop <= 1'b1;
        wait_drain("framing error");
        assert (!error_in_fifo)
            else fail_check($sformatf("Mismatch at %0t: error_in_fifo expected 0 got 1", $time));

        // Break of two character times low
        expected_q.push_back('{data: 8'h00, break_flag: 1'b1, parity_err: 1'b0,
                               framing_err: 1'b0});
        send_bit(1'b0, 2 * frame_ticks(fmt));
        send_bit(1'b1, 2 * OVERSAMPLE);
        wait_drain("break");
        repeat (2 * MAX_FRAME_TICKS) @(posedge clk);
        assert (rx_count == '0)
            else fail_check("Break produced more than one record");

        // Overrun
        auto_pop <= 1'b0;
        for (int i = 0; i < N_OVR; i++) begin
            data = 8'(take_bits(8));
            if (i < FIFO_DEPTH) begin
                expected_q.push_back(expected_record(data, fmt, 1'b0, 1'b0));
            end
            send_frame(data, fmt, 1'b0, 1'b0);
        end
        repeat (4) @(posedge clk);
        assert (rx_count == FIFO_COUNT_W'(FIFO_DEPTH))
            else fail_check($sformatf("Mismatch at %0t: rx_count expected %0d got %0d",
                                      $time, FIFO_DEPTH, rx_count));
        assert (overrun)
            else fail_check($sformatf("Mismatch at %0t: overrun expected 1 got 0", $time));
        auto_pop <= 1'b1;
        wait_drain("overrun read back");

        // One unread record left in the FIFO for the clear to remove
        auto_pop <= 1'b0;
        data = 8'(take_bits(8));
        send_frame(data, fmt, 1'b0, 1'b0);
        wait_cond_count(1, "waiting for a record to clear");
        assert (overrun)
            else fail_check($sformatf("Mismatch at %0t: overrun expected 1 got 0", $time));
        fifo_clear <= 1'b1;
        @(posedge clk);
        fifo_clear <= 1'b0;
        @(posedge clk);
        assert (rx_count == '0)
            else fail_check($sformatf("Mismatch at %0t: rx_count expected 0 got %0d", $time,
                                      rx_count));
        assert (!overrun)
            else fail_check($sformatf("Mismatch at %0t: overrun expected 0 got 1", $time));

        // Character timeout on one unread record
        data = 8'(take_bits(8));
        expected_q.push_back(expected_record(data, fmt, 1'b0, 1'b0));
        start_ticks = tick_total;
        send_frame(data, fmt, 1'b0, 1'b0);
        c = 0;
        while (!char_timeout) begin
            @(posedge clk);
            c++;
            if (c > 2 * (int'(char_ticks(fmt)) + frame_ticks(fmt))) begin
                fail_check("char_timeout never rose with a record waiting");
            end
        end
        elapsed = tick_total - start_ticks;
        assert (elapsed > int'(char_ticks(fmt)) &&
                elapsed <= int'(char_ticks(fmt)) + 1 + frame_ticks(fmt))
            else fail_check($sformatf("char_timeout rose after %0d ticks, out of range",
                                      elapsed));
        auto_pop <= 1'b1;
        wait_drain("timeout record");
        assert (!char_timeout)
            else fail_check($sformatf("Mismatch at %0t: char_timeout expected 0 got 1", $time));

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- uart_rx.f
hw/uart_rx_pkg.sv
hw/uart_rx_framer.sv
hw/uart_rx_line_timer.sv
hw/uart_rx_fifo.sv
hw/uart_rx_top.sv
dv/uart_rx_properties.sv
dv/uart_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the UART receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module uart_rx_tb -f uart_rx.f -o uart_rx_sim

# Simulation status is judged from the log below
./obj_dir/uart_rx_sim > sim.log 2>&1 || true
cat sim.log

grep -q "Simulation passed" sim.log
